//--- top_id.f
+incdir+common
common/mips_id_pkg.sv
common/id_fields_if.sv
decode/instr_field_decoder.sv
decode/main_control.sv
register_file/register_file.sv
hdl/branch_address_calculator.sv
hdl/top_id.sv
tests/top_id_asserts.sv
tests/tb_top_id.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert --timescale 1ns/1ps \
    --top-module tb_top_id -f top_id.f -o sim_top_id

# A crash or a nonzero exit counts as a failed run.
./obj_dir/sim_top_id +verilator+error+limit+1000 > sim.log 2>&1 \
    || echo "=== FAIL ===" >> sim.log
cat sim.log

if grep -q "=== FAIL ===" sim.log; then
    echo "Simulation failed, see sim.log."
    exit 1
fi
echo "Simulation passed."

//--- tests/tb_top_id.sv
`timescale 1ns/1ps

`include "mips_id_consts.svh"

module tb_top_id;

    logic                   i_clock;
    logic                   i_soft_reset;
    logic [`INSTR_W-1:0]    i_instruction;
    logic [`ADDR_W-1:0]     i_out_adder_pc;
    logic                   i_control_write_reg;
    logic [`REG_ADDR_W-1:0] i_reg_write;
    logic [`REG_W-1:0]      i_data_write;
    logic [`ADDR_W-1:0]     o_branch_dir;
    logic                   o_branch_control;
    logic [`REG_W-1:0]      o_data_a;
    logic [`REG_W-1:0]      o_data_b;
    logic [`REG_W-1:0]      o_extension_signo_constante;
    logic [`REG_ADDR_W-1:0] o_reg_rs;
    logic [`REG_ADDR_W-1:0] o_reg_rt;
    logic [`REG_ADDR_W-1:0] o_reg_rd;
    logic                   o_reg_dst;
    logic                   o_reg_write;
    logic                   o_alu_src;
    mips_id_pkg::alu_op_e   o_alu_op;
    logic                   o_mem_read;
    logic                   o_mem_write;
    logic                   o_mem_to_reg;
    mips_id_pkg::alu_ctrl_e o_alu_ctrl;

    logic [15:0]  lfsr_state;
    int unsigned  tests_passed;
    int unsigned  tests_failed;
    int unsigned  errors_at_start;
    int unsigned  timeouts;
    logic [5:0]   fn_codes [12] = '{6'h00, 6'h02, 6'h03, 6'h08, 6'h09, 6'h21,
                                    6'h23, 6'h24, 6'h25, 6'h26, 6'h27, 6'h2a};
    logic [5:0]   op_codes [12] = '{6'h02, 6'h03, 6'h04, 6'h05, 6'h08, 6'h0a,
                                    6'h0c, 6'h0d, 6'h0e, 6'h0f, 6'h23, 6'h2b};

    top_id i_dut (.*);

    initial begin
        i_clock = 1'b0;
        forever #50 i_clock = ~i_clock;
    end

    initial begin
        #100_000;
        $display("Watchdog expired before all tests finished.");
        $display("=== FAIL ===");
        $finish;
    end

    // Fibonacci LFSR with taps x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] value;
        logic        fb;
        value = '0;
        for (int k = 0; k < n; k++) begin
            fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};
            value = {value[30:0], fb};
        end
        return value;
    endfunction

    task automatic drive(input logic [31:0] instr, input logic [31:0] pc, input logic we,
                         input logic [31:0] wa, input logic [31:0] wd);
        @(posedge i_clock);
        #1;
        i_instruction       = instr;
        i_out_adder_pc      = pc[`ADDR_W-1:0];
        i_control_write_reg = we;
        i_reg_write         = wa[`REG_ADDR_W-1:0];
        i_data_write        = wd;
    endtask

    task automatic start_test();
        errors_at_start = i_dut.u_top_id_asserts.error_count;
        timeouts = 0;
    endtask

    task automatic finish_test(input string name);
        int unsigned errs;
        // Let the last instruction reach its check edge.
        @(posedge i_clock);
        #1;
        errs = i_dut.u_top_id_asserts.error_count - errors_at_start + timeouts;
        if (errs == 0) begin
            tests_passed++;
            $display("test %s: passed", name);
        end
        else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errs);
        end
    endtask

    task automatic wait_rtype_decoded();
        int cycles;
        cycles = 0;
        while (o_reg_dst !== 1'b1 && cycles < 8) begin
            @(posedge i_clock);
            cycles++;
        end
        if (o_reg_dst !== 1'b1) begin
            $display("Timeout: the first R-type instruction never reached the ID/EX register.");
            timeouts++;
        end
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] d;
        logic [31:0] a_val;
        logic [31:0] c_val;
        int          j;
        lfsr_state          = 16'd24;
        tests_passed        = 0;
        tests_failed        = 0;
        timeouts            = 0;
        i_soft_reset        = 1'b0;
        i_instruction       = {6'h00, 5'd1, 5'd2, 5'd3, 5'd0, 6'h21};
        i_out_adder_pc      = '0;
        i_control_write_reg = 1'b0;
        i_reg_write         = '0;
        i_data_write        = '0;

        ////////////////////
        // Reset.
        ////////////////////
        start_test();
        repeat (10) @(posedge i_clock);
        #1;
        i_soft_reset = 1'b1;
        wait_rtype_decoded();
        finish_test("reset");

        // Each write also reads the same register, so the old value must come back.
        start_test();
        for (int i = 0; i < `REG_COUNT; i++) begin
            r = take_bits(10);
            d = take_bits(32);
            drive({6'h00, i[4:0], r[9:5], r[4:0], 5'd0, 6'h21}, 0, 1'b1, i, d);
        end
        for (int i = 0; i < `REG_COUNT; i++) begin
            j = 31 - i;
            drive({6'h00, i[4:0], j[4:0], 5'd0, 5'd0, 6'h24}, 0, 1'b0, 0, 0);
        end
        finish_test("register file");

        start_test();
        for (int i = 0; i < 32; i++) begin
            r = take_bits(31);
            d = take_bits(`ADDR_W);
            drive({r[30:15], i[0], r[14:0]}, d, 1'b0, 0, 0);
        end
        finish_test("field and immediate decode");

        ////////////////////
        // Control table.
        ////////////////////
        start_test();
        for (int i = 0; i < 12; i++) begin
            r = take_bits(20);
            drive({6'h00, r[19:0], fn_codes[i]}, 0, 1'b0, 0, 0);
        end
        for (int i = 0; i < 12; i++) begin
            r = take_bits(26);
            drive({op_codes[i], r[25:0]}, 0, 1'b0, 0, 0);
        end
        drive({6'h3f, r[25:0]}, 0, 1'b0, 0, 0);
        drive({6'h00, r[19:0], 6'h3e}, 0, 1'b0, 0, 0);
        finish_test("control table");

        ////////////////////
        // Branches.
        ////////////////////
        start_test();
        a_val = take_bits(32);
        c_val = take_bits(32);
        drive(32'hfc00_0000, 0, 1'b1, 1, a_val);
        drive(32'hfc00_0000, 0, 1'b1, 2, a_val);
        drive(32'hfc00_0000, 0, 1'b1, 3, ~a_val);
        drive(32'hfc00_0000, 0, 1'b1, 4, c_val);
        r = take_bits(16);
        d = take_bits(`ADDR_W);
        drive({6'h04, 5'd1, 5'd2, r[15:0]}, d, 1'b0, 0, 0);
        drive({6'h04, 5'd1, 5'd3, r[15:0]}, d, 1'b0, 0, 0);
        drive({6'h05, 5'd1, 5'd3, r[15:0]}, d, 1'b0, 0, 0);
        drive({6'h05, 5'd1, 5'd2, r[15:0]}, d, 1'b0, 0, 0);
        r = take_bits(26);
        drive({6'h02, r[25:0]}, d, 1'b0, 0, 0);
        r = take_bits(26);
        drive({6'h03, r[25:0]}, d, 1'b0, 0, 0);
        drive({6'h00, 5'd4, 15'd0, 6'h08}, d, 1'b0, 0, 0);
        // Offset of -16 from PC 5 wraps below zero.
        drive({6'h04, 5'd1, 5'd2, 16'hfff0}, 5, 1'b0, 0, 0);
        finish_test("branches");

        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("=== PASS ===");
        end
        else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- tests/top_id_asserts.sv
`timescale 1ns/1ps

`include "mips_id_consts.svh"

module top_id_asserts (
    input logic                   i_clock,
    input logic                   i_soft_reset,
    input logic [`INSTR_W-1:0]    i_instruction,
    input logic [`ADDR_W-1:0]     i_out_adder_pc,
    input logic                   i_control_write_reg,
    input logic [`REG_ADDR_W-1:0] i_reg_write,
    input logic [`REG_W-1:0]      i_data_write,
    input logic [`ADDR_W-1:0]     o_branch_dir,
    input logic                   o_branch_control,
    input logic [`REG_W-1:0]      o_data_a,
    input logic [`REG_W-1:0]      o_data_b,
    input logic [`REG_W-1:0]      o_extension_signo_constante,
    input logic [`REG_ADDR_W-1:0] o_reg_rs,
    input logic [`REG_ADDR_W-1:0] o_reg_rt,
    input logic [`REG_ADDR_W-1:0] o_reg_rd,
    input logic                   o_reg_dst,
    input logic                   o_reg_write,
    input logic                   o_alu_src,
    input mips_id_pkg::alu_op_e   o_alu_op,
    input logic                   o_mem_read,
    input logic                   o_mem_write,
    input logic                   o_mem_to_reg,
    input mips_id_pkg::alu_ctrl_e o_alu_ctrl
);

    logic [`REG_W-1:0]                  shadow [`REG_COUNT];
    logic                               reset_seen = 1'b0;
    int unsigned                        error_count = 0;
    logic                               live;
    logic [`OPCODE_W-1:0]               op;
    logic [`OPCODE_W-1:0]               fn;
    logic [`REG_W-1:0]                  reg_a;
    logic [`REG_W-1:0]                  reg_b;
    logic signed [`IMM_W-1:0]           imm_raw;
    logic [`REG_W-1:0]                  imm_exp;
    logic [`ADDR_W-1:0]                 rel_target;
    logic [11:0]                        ctrl_got;
    logic [11:0]                        ctrl_exp;
    logic [3*`REG_ADDR_W+`REG_W-1:0]    fields_got;
    logic [3*`REG_ADDR_W+`REG_W-1:0]    fields_exp;
    logic [2*`REG_W-1:0]                data_got;
    logic [2*`REG_W-1:0]                data_exp;
    logic [`ADDR_W:0]                   branch_got;
    logic [`ADDR_W:0]                   branch_exp;

    function automatic logic [11:0] rtype_ctrl(input mips_id_pkg::alu_ctrl_e c);
        return {6'b110000, mips_id_pkg::ALUOP_RTYPE, c};
    endfunction

    function automatic logic [11:0] itype_ctrl(input mips_id_pkg::alu_ctrl_e c);
        return {6'b011000, mips_id_pkg::ALUOP_ITYPE, c};
    endfunction

    ////////////////////
    // Shadow register file.
    ////////////////////

    always @(posedge i_clock) begin
        if (!i_soft_reset) begin
            reset_seen <= 1'b1;
            for (int i = 0; i < `REG_COUNT; i++) begin
                shadow[i] <= '0;
            end
        end
        else if (i_control_write_reg && i_reg_write != '0) begin
            shadow[i_reg_write] <= i_data_write;
        end
    end

    assign live       = reset_seen && i_soft_reset;
    assign op         = i_instruction[`OPCODE_LSB +: `OPCODE_W];
    assign fn         = i_instruction[`OPCODE_W-1:0];
    assign reg_a      = shadow[i_instruction[`RS_LSB +: `REG_ADDR_W]];
    assign reg_b      = shadow[i_instruction[`RT_LSB +: `REG_ADDR_W]];
    assign imm_raw    = i_instruction[`IMM_W-1:0];
    assign imm_exp    = `REG_W'(imm_raw);
    assign rel_target = i_out_adder_pc + imm_exp[`ADDR_W-1:0];

    assign ctrl_got   = {o_reg_dst, o_reg_write, o_alu_src, o_mem_read, o_mem_write,
                         o_mem_to_reg, o_alu_op, o_alu_ctrl};
    assign fields_got = {o_reg_rs, o_reg_rt, o_reg_rd, o_extension_signo_constante};
    assign fields_exp = {i_instruction[`RS_LSB +: `REG_ADDR_W],
                         i_instruction[`RT_LSB +: `REG_ADDR_W],
                         i_instruction[`RD_LSB +: `REG_ADDR_W], imm_exp};
    assign data_got   = {o_data_a, o_data_b};
    assign data_exp   = {reg_a, reg_b};
    assign branch_got = {o_branch_control, o_branch_dir};

    // Control table with bits in ID/EX order.
    always_comb begin
        ctrl_exp = '0;
        case (op)
            6'h00: begin
                case (fn)
                    6'h21:   ctrl_exp = rtype_ctrl(mips_id_pkg::ALU_ADD);
                    6'h23:   ctrl_exp = rtype_ctrl(mips_id_pkg::ALU_SUB);
                    6'h24:   ctrl_exp = rtype_ctrl(mips_id_pkg::ALU_AND);
                    6'h25:   ctrl_exp = rtype_ctrl(mips_id_pkg::ALU_OR);
                    6'h26:   ctrl_exp = rtype_ctrl(mips_id_pkg::ALU_XOR);
                    6'h27:   ctrl_exp = rtype_ctrl(mips_id_pkg::ALU_NOR);
                    6'h2a:   ctrl_exp = rtype_ctrl(mips_id_pkg::ALU_SLT);
                    6'h00:   ctrl_exp = rtype_ctrl(mips_id_pkg::ALU_SLL);
                    6'h02:   ctrl_exp = rtype_ctrl(mips_id_pkg::ALU_SRL);
                    6'h03:   ctrl_exp = rtype_ctrl(mips_id_pkg::ALU_SRA);
                    6'h09:   ctrl_exp = {6'b010000, 6'd0};
                    default: ctrl_exp = '0;
                endcase
            end
            6'h08:   ctrl_exp = itype_ctrl(mips_id_pkg::ALU_ADD);
            6'h0a:   ctrl_exp = itype_ctrl(mips_id_pkg::ALU_SLT);
            6'h0c:   ctrl_exp = itype_ctrl(mips_id_pkg::ALU_AND);
            6'h0d:   ctrl_exp = itype_ctrl(mips_id_pkg::ALU_OR);
            6'h0e:   ctrl_exp = itype_ctrl(mips_id_pkg::ALU_XOR);
            6'h0f:   ctrl_exp = itype_ctrl(mips_id_pkg::ALU_LUI);
            6'h23:   ctrl_exp = {6'b011101, mips_id_pkg::ALUOP_LOADSTORE, mips_id_pkg::ALU_ADD};
            6'h2b:   ctrl_exp = {6'b001010, mips_id_pkg::ALUOP_LOADSTORE, mips_id_pkg::ALU_ADD};
            6'h04, 6'h05: begin
                ctrl_exp = {6'b000000, mips_id_pkg::ALUOP_BRANCH, mips_id_pkg::ALU_SUB};
            end
            6'h03:   ctrl_exp = {6'b010000, 6'd0};
            default: ctrl_exp = '0;
        endcase
    end

    // Branch decision as {taken, target}.
    always_comb begin
        branch_exp = '0;
        case (op)
            6'h04: begin
                if (reg_a == reg_b) begin
                    branch_exp = {1'b1, rel_target};
                end
            end
            6'h05: begin
                if (reg_a != reg_b) begin
                    branch_exp = {1'b1, rel_target};
                end
            end
            6'h02, 6'h03: branch_exp = {1'b1, i_instruction[`ADDR_W-1:0]};
            6'h00: begin
                if (fn == 6'h08 || fn == 6'h09) begin
                    branch_exp = {1'b1, reg_a[`ADDR_W-1:0]};
                end
            end
            default: begin
            end
        endcase
    end

    ////////////////////
    // Checks.
    ////////////////////

    a_reset_clear: assert property (@(posedge i_clock)
        (reset_seen && !i_soft_reset) |-> (ctrl_got == '0 && fields_got == '0 && data_got == '0))
        else begin
            error_count++;
            $error("** Error %0t id_ex register exp=0 got ctrl=%h fields=%h data=%h", $time,
                   $sampled(ctrl_got), $sampled(fields_got), $sampled(data_got));
        end

    a_fields: assert property (@(posedge i_clock) live |-> fields_got == fields_exp)
        else begin
            error_count++;
            $error("** Error %0t rs/rt/rd/imm exp=%h got=%h", $time,
                   $sampled(fields_exp), $sampled(fields_got));
        end

    a_data: assert property (@(posedge i_clock) live |-> data_got == data_exp)
        else begin
            error_count++;
            $error("** Error %0t o_data_a/o_data_b exp=%h got=%h", $time,
                   $sampled(data_exp), $sampled(data_got));
        end

    a_control: assert property (@(posedge i_clock) live |-> ctrl_got == ctrl_exp)
        else begin
            error_count++;
            $error("** Error %0t control bits exp=%h got=%h", $time,
                   $sampled(ctrl_exp), $sampled(ctrl_got));
        end

    a_branch: assert property (@(posedge i_clock) live |-> branch_got == branch_exp)
        else begin
            error_count++;
            $error("** Error %0t o_branch_control/o_branch_dir exp=%h got=%h", $time,
                   $sampled(branch_exp), $sampled(branch_got));
        end

endmodule

bind top_id top_id_asserts u_top_id_asserts (.*);

//--- hdl/top_id.sv
`timescale 1ns/1ps

`include "mips_id_consts.svh"

module top_id (
    input  logic                    i_clock,
    input  logic                    i_soft_reset,
    input  logic [`INSTR_W-1:0]     i_instruction,
    input  logic [`ADDR_W-1:0]      i_out_adder_pc,
    input  logic                    i_control_write_reg,
    input  logic [`REG_ADDR_W-1:0]  i_reg_write,
    input  logic [`REG_W-1:0]       i_data_write,
    output logic [`ADDR_W-1:0]      o_branch_dir,
    output logic                    o_branch_control,
    output logic [`REG_W-1:0]       o_data_a,
    output logic [`REG_W-1:0]       o_data_b,
    output logic [`REG_W-1:0]       o_extension_signo_constante,
    output logic [`REG_ADDR_W-1:0]  o_reg_rs,
    output logic [`REG_ADDR_W-1:0]  o_reg_rt,
    output logic [`REG_ADDR_W-1:0]  o_reg_rd,
    output logic                    o_reg_dst,
    output logic                    o_reg_write,
    output logic                    o_alu_src,
    output mips_id_pkg::alu_op_e    o_alu_op,
    output logic                    o_mem_read,
    output logic                    o_mem_write,
    output logic                    o_mem_to_reg,
    output mips_id_pkg::alu_ctrl_e  o_alu_ctrl
);

    id_fields_if fields ();

    logic [`REG_W-1:0]      data_a;
    logic [`REG_W-1:0]      data_b;
    logic [`REG_W-1:0]      imm_ext;
    logic                   reg_dst;
    logic                   reg_write;
    logic                   alu_src;
    logic                   mem_read;
    logic                   mem_write;
    logic                   mem_to_reg;
    mips_id_pkg::alu_op_e   alu_op;
    mips_id_pkg::alu_ctrl_e alu_ctrl;

    // Sign extension.
    assign imm_ext = {{(`REG_W - `IMM_W){fields.imm[`IMM_W-1]}}, fields.imm};

    instr_field_decoder u_instr_field_decoder (
        .i_instruction (i_instruction),
        .o_fields      (fields.producer)
    );

    main_control u_main_control (
        .i_fields     (fields.consumer),
        .o_reg_dst    (reg_dst),
        .o_reg_write  (reg_write),
        .o_alu_src    (alu_src),
        .o_mem_read   (mem_read),
        .o_mem_write  (mem_write),
        .o_mem_to_reg (mem_to_reg),
        .o_alu_op     (alu_op),
        .o_alu_ctrl   (alu_ctrl)
    );

    register_file u_register_file (
        .i_clock         (i_clock),
        .i_soft_reset    (i_soft_reset),
        .i_fields        (fields.consumer),
        .i_control_write (i_control_write_reg),
        .i_reg_write     (i_reg_write),
        .i_data_write    (i_data_write),
        .o_data_a        (data_a),
        .o_data_b        (data_b)
    );

    // Branch resolves in decode, outside the output register.
    branch_address_calculator u_branch_address_calculator (
        .i_fields         (fields.consumer),
        .i_adder_pc       (i_out_adder_pc),
        .i_data_a         (data_a),
        .i_data_b         (data_b),
        .i_imm_ext        (imm_ext),
        .o_branch_control (o_branch_control),
        .o_branch_dir     (o_branch_dir)
    );

    ////////////////////
    // ID/EX register on the falling edge.
    ////////////////////

    always_ff @(negedge i_clock) begin
        if (!i_soft_reset) begin
            o_data_a                    <= '0;
            o_data_b                    <= '0;
            o_extension_signo_constante <= '0;
            o_reg_rs                    <= '0;
            o_reg_rt                    <= '0;
            o_reg_rd                    <= '0;
            o_reg_dst                   <= 1'b0;
            o_reg_write                 <= 1'b0;
            o_alu_src                   <= 1'b0;
            o_alu_op                    <= mips_id_pkg::ALUOP_LOADSTORE;
            o_mem_read                  <= 1'b0;
            o_mem_write                 <= 1'b0;
            o_mem_to_reg                <= 1'b0;
            o_alu_ctrl                  <= mips_id_pkg::ALU_ADD;
        end
        else begin
            o_data_a                    <= data_a;
            o_data_b                    <= data_b;
            o_extension_signo_constante <= imm_ext;
            o_reg_rs                    <= fields.rs;
            o_reg_rt                    <= fields.rt;
            o_reg_rd                    <= fields.rd;
            o_reg_dst                   <= reg_dst;
            o_reg_write                 <= reg_write;
            o_alu_src                   <= alu_src;
            o_alu_op                    <= alu_op;
            o_mem_read                  <= mem_read;
            o_mem_write                 <= mem_write;
            o_mem_to_reg                <= mem_to_reg;
            o_alu_ctrl                  <= alu_ctrl;
        end
    end

endmodule

//--- hdl/branch_address_calculator.sv
`timescale 1ns/1ps

`include "mips_id_consts.svh"

module branch_address_calculator (
    id_fields_if.consumer      i_fields,
    input  logic [`ADDR_W-1:0] i_adder_pc,
    input  logic [`REG_W-1:0]  i_data_a,
    input  logic [`REG_W-1:0]  i_data_b,
    input  logic [`REG_W-1:0]  i_imm_ext,
    output logic               o_branch_control,
    output logic [`ADDR_W-1:0] o_branch_dir
);

    mips_id_pkg::branch_kind_e kind;
    logic                      operands_equal;
    logic [`ADDR_W-1:0]        rel_target;

    assign operands_equal = (i_data_a == i_data_b);

    // Wraps modulo the PC width.
    assign rel_target = i_adder_pc + i_imm_ext[`ADDR_W-1:0];

    ////////////////////
    // Branch kind.
    ////////////////////

    always_comb begin
        case (i_fields.opcode)
            mips_id_pkg::OP_BEQ: kind = mips_id_pkg::BR_BEQ;
            mips_id_pkg::OP_BNE: kind = mips_id_pkg::BR_BNE;
            mips_id_pkg::OP_J, mips_id_pkg::OP_JAL: begin
                kind = mips_id_pkg::BR_JUMP;
            end
            mips_id_pkg::OP_RTYPE: begin
                if (i_fields.funct == mips_id_pkg::FN_JR ||
                    i_fields.funct == mips_id_pkg::FN_JALR) begin
                    kind = mips_id_pkg::BR_JUMP_REG;
                end
                else begin
                    kind = mips_id_pkg::BR_NONE;
                end
            end
            default: kind = mips_id_pkg::BR_NONE;
        endcase
    end

    ////////////////////
    // Decision and target.
    ////////////////////

    always_comb begin
        o_branch_control = 1'b0;
        o_branch_dir     = '0;
        case (kind)
            mips_id_pkg::BR_BEQ: begin
                o_branch_control = operands_equal;
                o_branch_dir     = operands_equal ? rel_target : '0;
            end
            mips_id_pkg::BR_BNE: begin
                o_branch_control = !operands_equal;
                o_branch_dir     = operands_equal ? '0 : rel_target;
            end
            mips_id_pkg::BR_JUMP: begin
                o_branch_control = 1'b1;
                o_branch_dir     = i_fields.index[`ADDR_W-1:0];
            end
            mips_id_pkg::BR_JUMP_REG: begin
                o_branch_control = 1'b1;
                o_branch_dir     = i_data_a[`ADDR_W-1:0];
            end
            default: begin
            end
        endcase
    end

endmodule

//--- register_file/register_file.sv
`timescale 1ns/1ps

`include "mips_id_consts.svh"

module register_file (
    input  logic                   i_clock,
    input  logic                   i_soft_reset,
    id_fields_if.consumer          i_fields,
    input  logic                   i_control_write,
    input  logic [`REG_ADDR_W-1:0] i_reg_write,
    input  logic [`REG_W-1:0]      i_data_write,
    output logic [`REG_W-1:0]      o_data_a,
    output logic [`REG_W-1:0]      o_data_b
);

    logic [`REG_W-1:0] regs [`REG_COUNT];
    logic              write_en;

    // Register zero is never written.
    assign write_en = i_control_write && (i_reg_write != '0);

    ////////////////////
    // Write port.
    ////////////////////

    always_ff @(posedge i_clock) begin
        if (!i_soft_reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end
        else if (write_en) begin
            regs[i_reg_write] <= i_data_write;
        end
    end

    ////////////////////
    // Read ports.
    ////////////////////

    // No bypass. A same-cycle write shows up next cycle.
    always_comb begin
        if (i_fields.rs == '0) begin
            o_data_a = '0;
        end
        else begin
            o_data_a = regs[i_fields.rs];
        end

        if (i_fields.rt == '0) begin
            o_data_b = '0;
        end
        else begin
            o_data_b = regs[i_fields.rt];
        end
    end

endmodule

//--- decode/main_control.sv
`timescale 1ns/1ps

module main_control (
    id_fields_if.consumer           i_fields,
    output logic                    o_reg_dst,
    output logic                    o_reg_write,
    output logic                    o_alu_src,
    output logic                    o_mem_read,
    output logic                    o_mem_write,
    output logic                    o_mem_to_reg,
    output mips_id_pkg::alu_op_e    o_alu_op,
    output mips_id_pkg::alu_ctrl_e  o_alu_ctrl
);

    always_comb begin
        // Bubble unless a supported encoding says otherwise.
        o_reg_dst    = 1'b0;
        o_reg_write  = 1'b0;
        o_alu_src    = 1'b0;
        o_mem_read   = 1'b0;
        o_mem_write  = 1'b0;
        o_mem_to_reg = 1'b0;
        o_alu_op     = mips_id_pkg::ALUOP_LOADSTORE;
        o_alu_ctrl   = mips_id_pkg::ALU_ADD;

        case (i_fields.opcode)
            mips_id_pkg::OP_RTYPE: begin
                case (i_fields.funct)
                    mips_id_pkg::FN_JR: begin
                    end
                    mips_id_pkg::FN_JALR: begin
                        o_reg_write = 1'b1;
                    end
                    mips_id_pkg::FN_INVALID: begin
                    end
                    default: begin
                        o_reg_dst   = 1'b1;
                        o_reg_write = 1'b1;
                        o_alu_op    = mips_id_pkg::ALUOP_RTYPE;
                    end
                endcase

                // ALU operation straight from funct.
                case (i_fields.funct)
                    mips_id_pkg::FN_ADDU: o_alu_ctrl = mips_id_pkg::ALU_ADD;
                    mips_id_pkg::FN_SUBU: o_alu_ctrl = mips_id_pkg::ALU_SUB;
                    mips_id_pkg::FN_AND:  o_alu_ctrl = mips_id_pkg::ALU_AND;
                    mips_id_pkg::FN_OR:   o_alu_ctrl = mips_id_pkg::ALU_OR;
                    mips_id_pkg::FN_XOR:  o_alu_ctrl = mips_id_pkg::ALU_XOR;
                    mips_id_pkg::FN_NOR:  o_alu_ctrl = mips_id_pkg::ALU_NOR;
                    mips_id_pkg::FN_SLT:  o_alu_ctrl = mips_id_pkg::ALU_SLT;
                    mips_id_pkg::FN_SLL:  o_alu_ctrl = mips_id_pkg::ALU_SLL;
                    mips_id_pkg::FN_SRL:  o_alu_ctrl = mips_id_pkg::ALU_SRL;
                    mips_id_pkg::FN_SRA:  o_alu_ctrl = mips_id_pkg::ALU_SRA;
                    default:              o_alu_ctrl = mips_id_pkg::ALU_ADD;
                endcase
            end

            mips_id_pkg::OP_ADDI, mips_id_pkg::OP_SLTI, mips_id_pkg::OP_ANDI,
            mips_id_pkg::OP_ORI,  mips_id_pkg::OP_XORI, mips_id_pkg::OP_LUI: begin
                o_alu_src   = 1'b1;
                o_reg_write = 1'b1;
                o_alu_op    = mips_id_pkg::ALUOP_ITYPE;
                case (i_fields.opcode)
                    mips_id_pkg::OP_SLTI: o_alu_ctrl = mips_id_pkg::ALU_SLT;
                    mips_id_pkg::OP_ANDI: o_alu_ctrl = mips_id_pkg::ALU_AND;
                    mips_id_pkg::OP_ORI:  o_alu_ctrl = mips_id_pkg::ALU_OR;
                    mips_id_pkg::OP_XORI: o_alu_ctrl = mips_id_pkg::ALU_XOR;
                    mips_id_pkg::OP_LUI:  o_alu_ctrl = mips_id_pkg::ALU_LUI;
                    default:              o_alu_ctrl = mips_id_pkg::ALU_ADD;
                endcase
            end

            mips_id_pkg::OP_LW: begin
                o_alu_src    = 1'b1;
                o_mem_read   = 1'b1;
                o_mem_to_reg = 1'b1;
                o_reg_write  = 1'b1;
            end

            mips_id_pkg::OP_SW: begin
                o_alu_src   = 1'b1;
                o_mem_write = 1'b1;
            end

            // Compare is a subtract in execute.
            mips_id_pkg::OP_BEQ, mips_id_pkg::OP_BNE: begin
                o_alu_op   = mips_id_pkg::ALUOP_BRANCH;
                o_alu_ctrl = mips_id_pkg::ALU_SUB;
            end

            mips_id_pkg::OP_JAL: begin
                o_reg_write = 1'b1;
            end

            default: begin
            end
        endcase
    end

endmodule

//--- decode/instr_field_decoder.sv
`timescale 1ns/1ps

`include "mips_id_consts.svh"

module instr_field_decoder (
    input  logic [`INSTR_W-1:0] i_instruction,
    id_fields_if.producer       o_fields
);

    logic [`OPCODE_W-1:0] op_raw;
    logic [`OPCODE_W-1:0] fn_raw;

    assign op_raw = i_instruction[`OPCODE_LSB +: `OPCODE_W];
    assign fn_raw = i_instruction[`OPCODE_W-1:0];

    ////////////////////
    // Plain field slices.
    ////////////////////

    assign o_fields.rs    = i_instruction[`RS_LSB    +: `REG_ADDR_W];
    assign o_fields.rt    = i_instruction[`RT_LSB    +: `REG_ADDR_W];
    assign o_fields.rd    = i_instruction[`RD_LSB    +: `REG_ADDR_W];
    assign o_fields.shamt = i_instruction[`SHAMT_LSB +: `REG_ADDR_W];
    assign o_fields.imm   = i_instruction[`IMM_W-1:0];
    assign o_fields.index = i_instruction[`INDEX_W-1:0];

    ////////////////////
    // Opcode and function classification.
    ////////////////////

    always_comb begin
        case (op_raw)
            mips_id_pkg::OP_RTYPE, mips_id_pkg::OP_J,    mips_id_pkg::OP_JAL,
            mips_id_pkg::OP_BEQ,   mips_id_pkg::OP_BNE,  mips_id_pkg::OP_ADDI,
            mips_id_pkg::OP_SLTI,  mips_id_pkg::OP_ANDI, mips_id_pkg::OP_ORI,
            mips_id_pkg::OP_XORI,  mips_id_pkg::OP_LUI,  mips_id_pkg::OP_LW,
            mips_id_pkg::OP_SW: begin
                o_fields.opcode = mips_id_pkg::opcode_e'(op_raw);
            end
            default: begin
                o_fields.opcode = mips_id_pkg::OP_INVALID;
            end
        endcase
    end

    always_comb begin
        case (fn_raw)
            mips_id_pkg::FN_SLL,  mips_id_pkg::FN_SRL,  mips_id_pkg::FN_SRA,
            mips_id_pkg::FN_JR,   mips_id_pkg::FN_JALR, mips_id_pkg::FN_ADDU,
            mips_id_pkg::FN_SUBU, mips_id_pkg::FN_AND,  mips_id_pkg::FN_OR,
            mips_id_pkg::FN_XOR,  mips_id_pkg::FN_NOR,  mips_id_pkg::FN_SLT: begin
                o_fields.funct = mips_id_pkg::funct_e'(fn_raw);
            end
            default: begin
                o_fields.funct = mips_id_pkg::FN_INVALID;
            end
        endcase
    end

endmodule

//--- common/id_fields_if.sv
`timescale 1ns/1ps

`include "mips_id_consts.svh"

interface id_fields_if;

    logic [`REG_ADDR_W-1:0]  rs;
    logic [`REG_ADDR_W-1:0]  rt;
    logic [`REG_ADDR_W-1:0]  rd;
    logic [`REG_ADDR_W-1:0]  shamt;
    logic [`IMM_W-1:0]       imm;
    logic [`INDEX_W-1:0]     index;
    mips_id_pkg::opcode_e    opcode;
    mips_id_pkg::funct_e     funct;

    // Field decoder side.
    modport producer (
        output rs, rt, rd, shamt, imm, index, opcode, funct
    );

    // Control, branch and register file side.
    modport consumer (
        input rs, rt, rd, shamt, imm, index, opcode, funct
    );

endinterface

//--- common/mips_id_pkg.sv
`include "mips_id_consts.svh"

package mips_id_pkg;

    // Primary opcodes, encoded as in the MIPS32 opcode map.
    typedef enum logic [`OPCODE_W-1:0] {
        OP_RTYPE   = 6'h00,
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDI    = 6'h08,
        OP_SLTI    = 6'h0a,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b,
        OP_INVALID = 6'h3f
    } opcode_e;

    // SPECIAL function codes.
    typedef enum logic [`OPCODE_W-1:0] {
        FN_SLL     = 6'h00,
        FN_SRL     = 6'h02,
        FN_SRA     = 6'h03,
        FN_JR      = 6'h08,
        FN_JALR    = 6'h09,
        FN_ADDU    = 6'h21,
        FN_SUBU    = 6'h23,
        FN_AND     = 6'h24,
        FN_OR      = 6'h25,
        FN_XOR     = 6'h26,
        FN_NOR     = 6'h27,
        FN_SLT     = 6'h2a,
        FN_INVALID = 6'h3f
    } funct_e;

    // ALU operation class handed to execute.
    typedef enum logic [1:0] {
        ALUOP_LOADSTORE = 2'd0,
        ALUOP_BRANCH    = 2'd1,
        ALUOP_RTYPE     = 2'd2,
        ALUOP_ITYPE     = 2'd3
    } alu_op_e;

    // ALU control. ADD is zero so a bubble decodes to it.
    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_NOR = 4'd5,
        ALU_SLT = 4'd6,
        ALU_SLL = 4'd7,
        ALU_SRL = 4'd8,
        ALU_SRA = 4'd9,
        ALU_LUI = 4'd10
    } alu_ctrl_e;

    typedef enum logic [2:0] {
        BR_NONE,
        BR_BEQ,
        BR_BNE,
        BR_JUMP,
        BR_JUMP_REG
    } branch_kind_e;

endpackage

//--- common/mips_id_consts.svh
`ifndef MIPS_ID_CONSTS_SVH
`define MIPS_ID_CONSTS_SVH

// Instruction and data widths.
`define INSTR_W     32
`define REG_W       32
`define REG_COUNT   32
`define REG_ADDR_W  5

// Immediate, jump index and PC address widths.
`define IMM_W       16
`define INDEX_W     26
`define ADDR_W      11

// Opcode and function code width.
`define OPCODE_W    6

// Field positions inside the instruction word.
`define OPCODE_LSB  26
`define RS_LSB      21
`define RT_LSB      16
`define RD_LSB      11
`define SHAMT_LSB   6

`endif
